// ==== hdl/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    // ------------------------------------------------------------------
    // AXI field types
    // ------------------------------------------------------------------

    // Transaction ID
    typedef logic [3:0]  id_t;

    // Byte address
    typedef logic [31:0] addr_t;

    // Beats minus one
    typedef logic [7:0]  len_t;

    // log2 of bytes per beat
    typedef logic [2:0]  size_t;

    typedef logic [1:0]  burst_t;
    typedef logic [1:0]  resp_t;

    // R channel data
    typedef logic [63:0] data_t;

    // ------------------------------------------------------------------
    // Burst and response codes
    // ------------------------------------------------------------------

    localparam burst_t BURST_FIXED = 2'd0;
    localparam burst_t BURST_INCR  = 2'd1;
    localparam burst_t BURST_WRAP  = 2'd2;

    localparam resp_t  RESP_OKAY   = 2'd0;
    localparam resp_t  RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

// ==== hdl/rd_slave_pkg.sv ====
`default_nettype none

package rd_slave_pkg;

    // Longest burst a slot can buffer
    localparam int MAX_BURST_LEN = 8;

    // Beat position inside one burst
    typedef logic [2:0] beat_idx_t;

    // Fetch delay model where a beat takes FETCH_BASE_DLY minus ID cycles
    typedef logic [4:0] fetch_cnt_t;
    localparam fetch_cnt_t FETCH_BASE_DLY = 5'd24;

    // ID whose last beat answers with SLVERR
    localparam axi_pkg::id_t ERR_ID = 4'd15;

    // Slot occupancy
    typedef enum logic {
        SLOT_FREE,
        SLOT_ACTIVE
    } slot_state_t;

endpackage

`default_nettype wire

// ==== hdl/rr_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
    parameter int N = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [N-1:0]                        req,
    input  logic                                advance,
    output logic [((N > 1) ? $clog2(N) : 1)-1:0] ptr
);

    localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

    logic [PTR_W-1:0] nxt;

    // First requester above ptr, wrapping back to ptr itself last
    always_comb begin
        logic             found;
        logic [PTR_W-1:0] cand;
        nxt   = ptr;
        found = 1'b0;
        for (int unsigned k = 1; k <= N; k++) begin
            cand = ptr + PTR_W'(k);
            if (!found && req[cand]) begin
                nxt   = cand;
                found = 1'b1;
            end
        end
    end

    // Move on a grant, or step off an index that has nothing to offer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (|req && (advance || !req[ptr])) begin
            ptr <= nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/burst_addr_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module burst_addr_gen (
    input  axi_pkg::addr_t  start_addr,
    input  axi_pkg::addr_t  cur_addr,
    input  axi_pkg::len_t   len,
    input  axi_pkg::size_t  size,
    input  axi_pkg::burst_t burst,
    output axi_pkg::addr_t  next_addr
);

    axi_pkg::addr_t num_bytes;
    axi_pkg::addr_t aligned_addr;
    axi_pkg::addr_t wrap_window;
    axi_pkg::addr_t wrap_lo;
    axi_pkg::addr_t wrap_hi;
    axi_pkg::addr_t incr_addr;

    assign num_bytes    = axi_pkg::addr_t'(1) << size;
    assign aligned_addr = cur_addr & ~(num_bytes - 1'b1);

    // Window is beats times bytes, a power of two for legal WRAP lengths
    assign wrap_window  = num_bytes * (axi_pkg::addr_t'(len) + 1'b1);
    assign wrap_lo      = start_addr & ~(wrap_window - 1'b1);
    assign wrap_hi      = wrap_lo + wrap_window;

    // Only the first beat of an INCR burst may be unaligned
    assign incr_addr    = aligned_addr + num_bytes;

    always_comb begin
        case (burst)
            axi_pkg::BURST_FIXED: next_addr = start_addr;
            axi_pkg::BURST_INCR:  next_addr = incr_addr;
            axi_pkg::BURST_WRAP: begin
                if (incr_addr >= wrap_hi) begin
                    next_addr = wrap_lo;
                end else begin
                    next_addr = incr_addr;
                end
            end
            default: next_addr = cur_addr;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/ost_slot.sv ====
`timescale 1ns/10ps
`default_nettype none

module ost_slot (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  axi_pkg::id_t    ar_id,
    input  axi_pkg::addr_t  ar_addr,
    input  axi_pkg::len_t   ar_len,
    input  axi_pkg::size_t  ar_size,
    input  axi_pkg::burst_t ar_burst,
    input  logic            beat_taken,
    output logic            busy,
    output logic            beat_rdy,
    output axi_pkg::id_t    id,
    output axi_pkg::data_t  data,
    output axi_pkg::resp_t  resp,
    output logic            last
);

    localparam int PAD_W = $bits(axi_pkg::data_t) - $bits(axi_pkg::id_t)
                         - $bits(axi_pkg::addr_t);

    rd_slave_pkg::slot_state_t state;

    // Stored request
    axi_pkg::addr_t  start_addr;
    axi_pkg::len_t   len_q;
    axi_pkg::size_t  size_q;
    axi_pkg::burst_t burst_q;

    // Fetch side
    rd_slave_pkg::fetch_cnt_t fetch_tmr;
    rd_slave_pkg::fetch_cnt_t fetch_tgt;
    axi_pkg::addr_t           cur_addr;
    axi_pkg::addr_t           next_addr;
    rd_slave_pkg::beat_idx_t  fetch_cnt;
    logic                     fetch_done;
    logic                     fetch_fire;

    // Return side
    rd_slave_pkg::beat_idx_t  ret_cnt;
    rd_slave_pkg::beat_idx_t  last_idx;
    logic                     active;

    // Beat buffer
    axi_pkg::data_t buf_data [rd_slave_pkg::MAX_BURST_LEN];
    axi_pkg::resp_t buf_resp [rd_slave_pkg::MAX_BURST_LEN];

    assign active     = (state == rd_slave_pkg::SLOT_ACTIVE);
    assign last_idx   = rd_slave_pkg::beat_idx_t'(len_q);
    assign fetch_tgt  = rd_slave_pkg::FETCH_BASE_DLY - rd_slave_pkg::fetch_cnt_t'(id);
    assign fetch_fire = active && !fetch_done && (fetch_tmr == fetch_tgt);

    burst_addr_gen i_burst_addr_gen (
        .start_addr (start_addr),
        .cur_addr   (cur_addr),
        .len        (len_q),
        .size       (size_q),
        .burst      (burst_q),
        .next_addr  (next_addr)
    );

    // ------------------------------------------------------------------
    // Slot control
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= rd_slave_pkg::SLOT_FREE;
            fetch_tmr  <= '0;
            fetch_cnt  <= '0;
            ret_cnt    <= '0;
            fetch_done <= 1'b0;
        end else if (load) begin
            state      <= rd_slave_pkg::SLOT_ACTIVE;
            fetch_tmr  <= rd_slave_pkg::fetch_cnt_t'(1);
            fetch_cnt  <= '0;
            ret_cnt    <= '0;
            fetch_done <= 1'b0;
        end else if (active) begin
            // Timer restarts per beat until the whole burst is buffered
            if (fetch_fire) begin
                fetch_tmr <= rd_slave_pkg::fetch_cnt_t'(1);
                fetch_cnt <= fetch_cnt + 1'b1;
                if (fetch_cnt == last_idx) begin
                    fetch_done <= 1'b1;
                end
            end else if (!fetch_done) begin
                fetch_tmr <= fetch_tmr + 1'b1;
            end
            if (beat_taken) begin
                ret_cnt <= ret_cnt + 1'b1;
                if (last) begin
                    state <= rd_slave_pkg::SLOT_FREE;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Request payload and beat buffer
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            id         <= ar_id;
            start_addr <= ar_addr;
            cur_addr   <= ar_addr;
            len_q      <= ar_len;
            size_q     <= ar_size;
            burst_q    <= ar_burst;
        end else if (fetch_fire) begin
            // Synthetic read data carries ID and beat address
            buf_data[fetch_cnt] <= {{PAD_W{1'b0}}, id, cur_addr};
            buf_resp[fetch_cnt] <= (id == rd_slave_pkg::ERR_ID && fetch_cnt == last_idx) ?
                                   axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
            cur_addr            <= next_addr;
        end
    end

    // Oldest unreturned beat
    assign busy     = active;
    assign beat_rdy = active && (fetch_done || (fetch_cnt != ret_cnt));
    assign data     = buf_data[ret_cnt];
    assign resp     = buf_resp[ret_cnt];
    assign last     = (ret_cnt == last_idx);

endmodule

`default_nettype wire

// ==== hdl/r_return_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module r_return_mux #(
    parameter int N = 16
) (
    input  logic [((N > 1) ? $clog2(N) : 1)-1:0] ptr,
    input  logic [N-1:0]                         beat_rdy,
    input  logic [N-1:0]                         last,
    input  axi_pkg::id_t                         id   [N],
    input  axi_pkg::data_t                       data [N],
    input  axi_pkg::resp_t                       resp [N],
    output logic                                 rvalid,
    output axi_pkg::id_t                         rid,
    output axi_pkg::data_t                       rdata,
    output axi_pkg::resp_t                       rresp,
    output logic                                 rlast
);

    // Fields of the slot under the return pointer
    assign rvalid = beat_rdy[ptr];
    assign rid    = id[ptr];
    assign rdata  = data[ptr];
    assign rresp  = resp[ptr];

    // Never raise rlast on an idle bus
    assign rlast  = last[ptr] & rvalid;

endmodule

`default_nettype wire

// ==== hdl/axi_rd_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_rd_slave #(
    parameter int OST_DEPTH = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    // AR channel
    input  logic            arvalid,
    output logic            arready,
    input  axi_pkg::id_t    arid,
    input  axi_pkg::addr_t  araddr,
    input  axi_pkg::len_t   arlen,
    input  axi_pkg::size_t  arsize,
    input  axi_pkg::burst_t arburst,
    // R channel
    output logic            rvalid,
    input  logic            rready,
    output axi_pkg::id_t    rid,
    output axi_pkg::data_t  rdata,
    output axi_pkg::resp_t  rresp,
    output logic            rlast
);

    localparam int PTR_W = (OST_DEPTH > 1) ? $clog2(OST_DEPTH) : 1;

    logic                 ar_hs;
    logic                 r_hs;
    logic [PTR_W-1:0]     alloc_ptr;
    logic [PTR_W-1:0]     ret_ptr;
    logic [OST_DEPTH-1:0] slot_busy;
    logic [OST_DEPTH-1:0] slot_free;
    logic [OST_DEPTH-1:0] slot_rdy;
    logic [OST_DEPTH-1:0] slot_last;
    axi_pkg::id_t         slot_id   [OST_DEPTH];
    axi_pkg::data_t       slot_data [OST_DEPTH];
    axi_pkg::resp_t       slot_resp [OST_DEPTH];

    assign ar_hs     = arvalid & arready;
    assign r_hs      = rvalid & rready;
    assign slot_free = ~slot_busy;

    // Alloc pointer parks on a free slot whenever one exists
    assign arready   = slot_free[alloc_ptr];

    // ------------------------------------------------------------------
    // Slot allocation and return order
    // ------------------------------------------------------------------
    rr_arbiter #(.N(OST_DEPTH)) i_alloc_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (slot_free),
        .advance (ar_hs),
        .ptr     (alloc_ptr)
    );

    rr_arbiter #(.N(OST_DEPTH)) i_return_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (slot_rdy),
        .advance (r_hs),
        .ptr     (ret_ptr)
    );

    // ------------------------------------------------------------------
    // Outstanding slots
    // ------------------------------------------------------------------
    for (genvar i = 0; i < OST_DEPTH; i++) begin : g_slot
        logic load;
        logic beat_taken;

        assign load       = ar_hs & (alloc_ptr == PTR_W'(i));
        assign beat_taken = r_hs & (ret_ptr == PTR_W'(i));

        ost_slot i_ost_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .load       (load),
            .ar_id      (arid),
            .ar_addr    (araddr),
            .ar_len     (arlen),
            .ar_size    (arsize),
            .ar_burst   (arburst),
            .beat_taken (beat_taken),
            .busy       (slot_busy[i]),
            .beat_rdy   (slot_rdy[i]),
            .id         (slot_id[i]),
            .data       (slot_data[i]),
            .resp       (slot_resp[i]),
            .last       (slot_last[i])
        );
    end

    r_return_mux #(.N(OST_DEPTH)) i_r_return_mux (
        .ptr      (ret_ptr),
        .beat_rdy (slot_rdy),
        .last     (slot_last),
        .id       (slot_id),
        .data     (slot_data),
        .resp     (slot_resp),
        .rvalid   (rvalid),
        .rid      (rid),
        .rdata    (rdata),
        .rresp    (rresp),
        .rlast    (rlast)
    );

endmodule

`default_nettype wire

// ==== tb/axi_rd_slave_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_rd_slave_assertions (
    input logic           clk,
    input logic           rst_n,
    input logic           rvalid,
    input logic           rready,
    input axi_pkg::id_t   rid,
    input axi_pkg::data_t rdata,
    input axi_pkg::resp_t rresp,
    input logic           rlast
);

    // A stalled beat holds until it transfers
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rid) && $stable(rdata)
                                 && $stable(rresp) && $stable(rlast)))
        else $error("R channel changed while stalled");

    a_rlast_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rlast |-> rvalid)
        else $error("rlast high without rvalid");

    // Quiet bus in reset and on the first cycle out of it
    a_rvalid_in_reset: assert property (@(posedge clk) !rst_n |-> !rvalid)
        else $error("rvalid high during reset");

    a_rvalid_after_reset: assert property (@(posedge clk) !rst_n |=> !rvalid)
        else $error("rvalid high right after reset");

endmodule

bind axi_rd_slave axi_rd_slave_assertions i_axi_rd_slave_assertions (
    .clk    (clk),
    .rst_n  (rst_n),
    .rvalid (rvalid),
    .rready (rready),
    .rid    (rid),
    .rdata  (rdata),
    .rresp  (rresp),
    .rlast  (rlast)
);

`default_nettype wire

// ==== tb/tb_axi_rd_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_axi_rd_slave;

    localparam int NUM_ROWS      = 12;
    localparam int AR_TIMEOUT    = 1000;
    localparam int DRAIN_TIMEOUT = 5000;

    // ------------------------------------------------------------------
    // Stimulus table where rows 0 to 3 go in while rready is held low
    // ------------------------------------------------------------------
    localparam axi_pkg::id_t TBL_ID [NUM_ROWS] = '{
        4'd1, 4'd2, 4'd3, 4'd15, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd0, 4'd9, 4'd10
    };
    localparam axi_pkg::addr_t TBL_ADDR [NUM_ROWS] = '{
        32'h1000, 32'h2002, 32'h3004, 32'h4000, 32'h5010, 32'h6038,
        32'h7008, 32'h8003, 32'h9000, 32'ha006, 32'hb000, 32'hc01c
    };
    localparam axi_pkg::len_t TBL_LEN [NUM_ROWS] = '{
        8'd0, 8'd3, 8'd7, 8'd3, 8'd3, 8'd3, 8'd7, 8'd3, 8'd7, 8'd1, 8'd7, 8'd7
    };
    localparam axi_pkg::size_t TBL_SIZE [NUM_ROWS] = '{
        3'd0, 3'd1, 3'd2, 3'd2, 3'd2, 3'd3, 3'd2, 3'd2, 3'd0, 3'd1, 3'd3, 3'd2
    };
    localparam axi_pkg::burst_t TBL_BURST [NUM_ROWS] = '{
        axi_pkg::BURST_INCR,  axi_pkg::BURST_INCR,  axi_pkg::BURST_INCR,
        axi_pkg::BURST_INCR,  axi_pkg::BURST_FIXED, axi_pkg::BURST_WRAP,
        axi_pkg::BURST_WRAP,  axi_pkg::BURST_INCR,  axi_pkg::BURST_INCR,
        axi_pkg::BURST_WRAP,  axi_pkg::BURST_FIXED, axi_pkg::BURST_INCR
    };

    logic            clk;
    logic            rst_n;
    logic            arvalid;
    logic            arready;
    axi_pkg::id_t    arid;
    axi_pkg::addr_t  araddr;
    axi_pkg::len_t   arlen;
    axi_pkg::size_t  arsize;
    axi_pkg::burst_t arburst;
    logic            rvalid;
    logic            rready;
    axi_pkg::id_t    rid;
    axi_pkg::data_t  rdata;
    axi_pkg::resp_t  rresp;
    logic            rlast;

    logic            stall_r;
    int              pending;

    // Expected beats per ID packed as {last, resp, data}
    logic [66:0]     exp_q [16][$];

    axi_rd_slave #(.OST_DEPTH(4)) i_axi_rd_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Failure reporting and checks
    // ------------------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check(input string name, input logic [66:0] got, input logic [66:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic axi_pkg::addr_t beat_addr(input int row, input int n);
        axi_pkg::addr_t nbytes;
        axi_pkg::addr_t window;
        axi_pkg::addr_t lo;
        axi_pkg::addr_t start;
        start  = TBL_ADDR[row];
        nbytes = 32'd1 << TBL_SIZE[row];
        window = nbytes * (32'(TBL_LEN[row]) + 32'd1);
        lo     = start & ~(window - 32'd1);
        case (TBL_BURST[row])
            axi_pkg::BURST_FIXED: return start;
            axi_pkg::BURST_WRAP:  return lo + ((start - lo + 32'(n) * nbytes) % window);
            default: begin
                // First beat keeps its offset, later beats are aligned
                if (n == 0) begin
                    return start;
                end
                return (start & ~(nbytes - 32'd1)) + 32'(n) * nbytes;
            end
        endcase
    endfunction

    task automatic push_expected(input int row);
        axi_pkg::id_t   id;
        axi_pkg::resp_t resp;
        axi_pkg::data_t data;
        logic           last;
        id = TBL_ID[row];
        for (int n = 0; n <= int'(TBL_LEN[row]); n++) begin
            last = (n == int'(TBL_LEN[row]));
            resp = (last && id == rd_slave_pkg::ERR_ID) ? axi_pkg::RESP_SLVERR
                                                        : axi_pkg::RESP_OKAY;
            data = {28'd0, id, beat_addr(row, n)};
            exp_q[id].push_back({last, resp, data});
            pending++;
        end
    endtask

    // ------------------------------------------------------------------
    // AR driver called 1 ns after a rising edge
    // ------------------------------------------------------------------
    task automatic send_request(input int row);
        int cycles;
        push_expected(row);
        arvalid = 1'b1;
        arid    = TBL_ID[row];
        araddr  = TBL_ADDR[row];
        arlen   = TBL_LEN[row];
        arsize  = TBL_SIZE[row];
        arburst = TBL_BURST[row];
        cycles  = 0;
        @(negedge clk);
        while (!arready) begin
            cycles++;
            if (cycles > AR_TIMEOUT) begin
                fail_run($sformatf("Timeout waiting for arready on table row %0d", row));
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (pending != 0 || rvalid) begin
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                fail_run($sformatf("Timeout with %0d read beats still missing", pending));
            end
            @(negedge clk);
        end
    endtask

    // Random back-pressure that stays off while stall_r is set
    initial begin
        void'($urandom(18));
        rready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rready = stall_r ? 1'b0 : (($urandom % 3) != 0);
        end
    end

    // ------------------------------------------------------------------
    // R monitor sampling mid-cycle where everything is settled
    // ------------------------------------------------------------------
    initial begin
        logic [66:0]  exp;
        logic [66:0]  held;
        axi_pkg::id_t held_id;
        logic         stalled;
        stalled = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                check("rlast without rvalid", 67'(rlast & ~rvalid), 67'd0);
                if (stalled) begin
                    check("rvalid while stalled", 67'(rvalid), 67'd1);
                    check("rid while stalled", 67'(rid), 67'(held_id));
                    check("R fields while stalled", {rlast, rresp, rdata}, held);
                end
                if (rvalid && rready) begin
                    if (exp_q[rid].size() == 0) begin
                        fail_run($sformatf("A beat with RID %0d arrived but none was due", rid));
                    end
                    exp = exp_q[rid].pop_front();
                    check("rdata", 67'(rdata), 67'(exp[63:0]));
                    check("rresp", 67'(rresp), 67'(exp[65:64]));
                    check("rlast", 67'(rlast), 67'(exp[66]));
                    pending--;
                end
                stalled = rvalid && !rready;
                held    = {rlast, rresp, rdata};
                held_id = rid;
            end
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        rst_n      = 1'b0;
        arvalid    = 1'b0;
        arid       = '0;
        araddr     = '0;
        arlen      = '0;
        arsize     = '0;
        arburst    = '0;
        stall_r    = 1'b1;
        pending    = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        check("arready after reset", 67'(arready), 67'd1);
        check("rvalid after reset", 67'(rvalid), 67'd0);
        @(posedge clk);
        #1;

        // Fill every slot with the R channel stalled
        for (int row = 0; row < 4; row++) begin
            send_request(row);
        end
        repeat (32) begin
            @(negedge clk);
            check("arready with all slots busy", 67'(arready), 67'd0);
        end
        stall_r = 1'b0;
        @(posedge clk);
        #1;

        // Back to back requests so bursts interleave
        for (int row = 4; row < NUM_ROWS; row++) begin
            send_request(row);
        end
        wait_idle();

        // Every slot has freed itself once its last beat went out
        check("arready after drain", 67'(arready), 67'd1);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/axi_pkg.sv
hdl/rd_slave_pkg.sv
hdl/rr_arbiter.sv
hdl/burst_addr_gen.sv
hdl/ost_slot.sv
hdl/r_return_mux.sv
hdl/axi_rd_slave.sv
tb/axi_rd_slave_assertions.sv
tb/tb_axi_rd_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI read slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_rd_slave -Mdir obj_dir -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_axi_rd_slave
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
